// File: hdl/bus_pkg.sv
package bus_pkg;

    // bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // 4 KB of block RAM, reached through the low address bits
    localparam int RAM_ADDR_W = 12;

    // width of the upper address byte that selects a page
    localparam int PAGE_W = 8;

    // register pages at the top of the map
    localparam logic [PAGE_W-1:0] TIMER_PAGE = 8'hFD;
    localparam logic [PAGE_W-1:0] PRNG_PAGE  = 8'hFE;
    localparam logic [PAGE_W-1:0] LEDS_PAGE  = 8'hFF;

    // slave count and index width
    localparam int N_SLAVES = 4;
    localparam int SLV_W    = 2;

    // slave indices into the select vector
    localparam logic [SLV_W-1:0] SLV_RAM   = 2'd0;
    localparam logic [SLV_W-1:0] SLV_LEDS  = 2'd1;
    localparam logic [SLV_W-1:0] SLV_PRNG  = 2'd2;
    localparam logic [SLV_W-1:0] SLV_TIMER = 2'd3;

endpackage

// File: hdl/periph_pkg.sv
package periph_pkg;

    // galois feedback mask, x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [7:0] PRNG_TAPS = 8'hB8;

    // lfsr state after reset
    localparam logic [7:0] PRNG_SEED = 8'h01;

    // timer register offsets, address bits 1..0
    localparam logic [1:0] TMR_RELOAD_LO = 2'd0;
    localparam logic [1:0] TMR_RELOAD_HI = 2'd1;
    localparam logic [1:0] TMR_CTRL      = 2'd2;
    localparam logic [1:0] TMR_STATUS    = 2'd3;

    // control register bits
    localparam int TMR_EN_BIT  = 0;
    localparam int TMR_CLR_BIT = 1;

endpackage

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic [ADDR_W-1:0]                adr_i,
    input  logic                             stb_i,
    input  logic [N_SLAVES-1:0][DATA_W-1:0]  slv_dat_i,
    input  logic [N_SLAVES-1:0]              slv_ack_i,
    output logic [N_SLAVES-1:0]              slv_stb_o,
    output logic [DATA_W-1:0]                dat_o,
    output logic                             ack_o
);

    logic [PAGE_W-1:0] page;
    logic [SLV_W-1:0]  sel;

    assign page = adr_i[ADDR_W-1 -: PAGE_W];

    // page decode, everything not claimed by a register page is RAM
    always_comb begin
        case (page)
            TIMER_PAGE: sel = SLV_TIMER;
            PRNG_PAGE:  sel = SLV_PRNG;
            LEDS_PAGE:  sel = SLV_LEDS;
            default:    sel = SLV_RAM;
        endcase
    end

    // strobe only reaches the selected slave
    always_comb begin
        slv_stb_o      = '0;
        slv_stb_o[sel] = stb_i;
    end

    // return path follows the same select
    // the master holds the address until ack, so sel stays valid
    assign dat_o = slv_dat_i[sel];
    assign ack_o = slv_ack_i[sel];

    // never more than one slave answering at a time
    a_one_ack: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(slv_ack_i)
    );

    // any slave ack must answer a strobe sampled on the previous edge
    a_ack_has_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (|slv_ack_i) |-> $past(stb_i)
    );

endmodule

// File: hdl/bram_wb8.sv
`timescale 1ns/1ps

module bram_wb8 import bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [RAM_ADDR_W-1:0] adr_i,
    input  logic [DATA_W-1:0]     dat_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    output logic [DATA_W-1:0]     dat_o,
    output logic                  ack_o
);

    localparam int DEPTH = 1 << RAM_ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic              access;

    // first cycle of a strobe only
    assign access = stb_i && !ack_o;

    // cells start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // single port, read data registered with the ack
    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

// File: hdl/leds_wb8.sv
`timescale 1ns/1ps

module leds_wb8 import bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [DATA_W-1:0] dat_i,
    input  logic              stb_i,
    input  logic              we_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic [DATA_W-1:0] leds_o
);

    logic access;

    assign access = stb_i && !ack_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o  <= 1'b0;
            leds_o <= '0;
        end else begin
            ack_o <= access;
            // led byte changes on the acking edge
            if (access && we_i) begin
                leds_o <= dat_i;
            end
        end
    end

    // readback of the stored byte
    always_ff @(posedge clk) begin
        if (access) begin
            dat_o <= leds_o;
        end
    end

endmodule

// File: hdl/prng_wb8.sv
`timescale 1ns/1ps

module prng_wb8 import bus_pkg::*, periph_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [DATA_W-1:0] dat_i,
    input  logic              stb_i,
    input  logic              we_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o
);

    logic [DATA_W-1:0] state_q;
    logic              access;

    // one right-shifting galois step
    function automatic logic [DATA_W-1:0] lfsr_step(input logic [DATA_W-1:0] s);
        lfsr_step = (s >> 1) ^ (s[0] ? PRNG_TAPS : '0);
    endfunction

    assign access = stb_i && !ack_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o   <= 1'b0;
            state_q <= PRNG_SEED;
        end else begin
            ack_o <= access;
            if (access) begin
                if (we_i) begin
                    // zero would lock the lfsr, restart from the seed
                    state_q <= (dat_i == '0) ? PRNG_SEED : dat_i;
                end else begin
                    state_q <= lfsr_step(state_q);
                end
            end
        end
    end

    // current state goes out, the next one is already computed
    always_ff @(posedge clk) begin
        if (access) begin
            dat_o <= state_q;
        end
    end

    a_state_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        state_q != '0
    );

endmodule

// File: hdl/timer_wb8.sv
`timescale 1ns/1ps

module timer_wb8 import bus_pkg::*, periph_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [1:0]        adr_i,
    input  logic [DATA_W-1:0] dat_i,
    input  logic              stb_i,
    input  logic              we_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic              irq_o
);

    logic [15:0] reload_q;
    logic [15:0] cnt_q;
    logic        en_q;
    logic        access;

    assign access = stb_i && !ack_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o    <= 1'b0;
            reload_q <= '0;
            cnt_q    <= '0;
            en_q     <= 1'b0;
            irq_o    <= 1'b0;
        end else begin
            ack_o <= access;
            // count down, reload and flag on zero
            if (en_q) begin
                if (cnt_q == '0) begin
                    cnt_q <= reload_q;
                    irq_o <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 16'd1;
                end
            end
            // register writes come last so a clear wins over a new flag
            if (access && we_i) begin
                case (adr_i)
                    TMR_RELOAD_LO: reload_q[7:0]  <= dat_i;
                    TMR_RELOAD_HI: reload_q[15:8] <= dat_i;
                    TMR_CTRL: begin
                        en_q <= dat_i[TMR_EN_BIT];
                        if (dat_i[TMR_EN_BIT]) begin
                            cnt_q <= reload_q;
                        end
                        if (dat_i[TMR_CLR_BIT]) begin
                            irq_o <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // clear bit is a strobe and reads back as zero
    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                TMR_RELOAD_LO: dat_o <= reload_q[7:0];
                TMR_RELOAD_HI: dat_o <= reload_q[15:8];
                TMR_CTRL:      dat_o <= {{(DATA_W-1){1'b0}}, en_q};
                default:       dat_o <= {{(DATA_W-1){1'b0}}, irq_o};
            endcase
        end
    end

endmodule

// File: hdl/soc_top.sv
`timescale 1ns/1ps

module soc_top import bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic [DATA_W-1:0] dat_i,
    input  logic              stb_i,
    input  logic              we_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic [DATA_W-1:0] leds_o,
    output logic              irq_o
);

    logic [N_SLAVES-1:0]             slv_stb;
    logic [N_SLAVES-1:0]             slv_ack;
    logic [N_SLAVES-1:0][DATA_W-1:0] slv_dat;

    bus_arbiter u_arbiter (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .adr_i     (adr_i),
        .stb_i     (stb_i),
        .slv_dat_i (slv_dat),
        .slv_ack_i (slv_ack),
        .slv_stb_o (slv_stb),
        .dat_o     (dat_o),
        .ack_o     (ack_o)
    );

    // default region, aliased every 4 KB
    bram_wb8 u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .adr_i   (adr_i[RAM_ADDR_W-1:0]),
        .dat_i   (dat_i),
        .stb_i   (slv_stb[SLV_RAM]),
        .we_i    (we_i),
        .dat_o   (slv_dat[SLV_RAM]),
        .ack_o   (slv_ack[SLV_RAM])
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dat_i   (dat_i),
        .stb_i   (slv_stb[SLV_LEDS]),
        .we_i    (we_i),
        .dat_o   (slv_dat[SLV_LEDS]),
        .ack_o   (slv_ack[SLV_LEDS]),
        .leds_o  (leds_o)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dat_i   (dat_i),
        .stb_i   (slv_stb[SLV_PRNG]),
        .we_i    (we_i),
        .dat_o   (slv_dat[SLV_PRNG]),
        .ack_o   (slv_ack[SLV_PRNG])
    );

    timer_wb8 u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .adr_i   (adr_i[1:0]),
        .dat_i   (dat_i),
        .stb_i   (slv_stb[SLV_TIMER]),
        .we_i    (we_i),
        .dat_o   (slv_dat[SLV_TIMER]),
        .ack_o   (slv_ack[SLV_TIMER]),
        .irq_o   (irq_o)
    );

endmodule

// File: tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps

module tb_top import bus_pkg::*, periph_pkg::*; ();

    localparam int N_RAM_OPS  = 200;
    localparam int N_LED_OPS  = 16;
    localparam int N_PRNG_RD  = 12;
    localparam int MAX_RELOAD = 40;
    localparam int ACK_LIMIT  = 4;
    // bus accesses of all tests, rounded up for the timer register traffic
    localparam int N_ACCESS   = N_RAM_OPS + 2 * N_LED_OPS + 3 * N_PRNG_RD + 24;
    localparam int TIMER_CYC  = 3 * (MAX_RELOAD + 1) + 64;
    localparam int WDOG_CYC   = N_ACCESS * 10 + TIMER_CYC;

    localparam logic [ADDR_W-1:0] LEDS_ADR = {LEDS_PAGE, 8'h00};
    localparam logic [ADDR_W-1:0] PRNG_ADR = {PRNG_PAGE, 8'h00};
    localparam logic [DATA_W-1:0] CTRL_EN  = 8'(1 << TMR_EN_BIT);
    localparam logic [DATA_W-1:0] CTRL_CLR = 8'(1 << TMR_CLR_BIT);

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] adr_i;
    logic [DATA_W-1:0] dat_i;
    logic              stb_i;
    logic              we_i;
    logic [DATA_W-1:0] dat_o;
    logic              ack_o;
    logic [DATA_W-1:0] leds_o;
    logic              irq_o;

    // reference model
    logic [DATA_W-1:0] ram_model [1 << RAM_ADDR_W];
    logic [DATA_W-1:0] leds_model;
    logic [DATA_W-1:0] prng_model;
    logic [15:0]       tmr_reload;
    logic              tmr_en;
    logic              tmr_pending;

    logic [15:0]       lfsr_q;
    int                cyc = 0;
    int                ack_cyc;
    // led byte seen in the ack cycle
    logic [DATA_W-1:0] ack_leds;

    tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(2)) u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    soc_top u_dut (
        .clk     (clk),
        .rst_n_i (rst_n),
        .adr_i   (adr_i),
        .dat_i   (dat_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .dat_o   (dat_o),
        .ack_o   (ack_o),
        .leds_o  (leds_o),
        .irq_o   (irq_o)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // 16-bit galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // expected prng value after one read
    function automatic logic [7:0] galois_next(input logic [7:0] s);
        logic [7:0] n;
        n = {1'b0, s[7:1]};
        if (s[0]) begin
            n = n ^ PRNG_TAPS;
        end
        return n;
    endfunction

    function automatic logic [ADDR_W-1:0] tmr_adr(input logic [1:0] reg_off);
        return {TIMER_PAGE, 6'd0, reg_off};
    endfunction

    // one strobe/ack transfer, also checks the ack timing
    task automatic bus_access(input logic [ADDR_W-1:0] adr, input logic we,
                              input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
        int waited;
        @(negedge clk);
        adr_i  = adr;
        dat_i  = wdat;
        we_i   = we;
        stb_i  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack_o && waited < ACK_LIMIT);
        if (!ack_o) begin
            fail_run($sformatf("no ack for address 0x%04h within %0d cycles", adr, ACK_LIMIT));
        end
        check_value("ack_o latency", 32'd1, waited);
        rdat     = dat_o;
        ack_cyc  = cyc;
        ack_leds = leds_o;
        @(negedge clk);
        // ack lasts a single cycle
        check_value("ack_o", 32'd0, 32'(ack_o));
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat);
        logic [DATA_W-1:0] rdat_ignored;
        bus_access(adr, 1'b1, wdat, rdat_ignored);
    endtask

    task automatic read_expect(input string name, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] rdat;
        bus_access(adr, 1'b0, 8'h00, rdat);
        check_value(name, 32'(exp), 32'(rdat));
    endtask

    task automatic irq_delay(input int limit, output int cycles);
        while (!irq_o) begin
            if (cyc - ack_cyc > limit) begin
                fail_run("irq_o did not rise after the timer was enabled");
            end else begin
                @(negedge clk);
            end
        end
        cycles = cyc - ack_cyc;
    endtask

    task automatic ram_traffic();
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] wdat;
        for (int n = 0; n < N_RAM_OPS; n++) begin
            // mostly a small window, reached through random alias bits
            if (rand_bits(2) != 0) begin
                adr = {4'(rand_bits(4)), 7'd0, 5'(rand_bits(5))};
            end else begin
                adr = 16'(rand_bits(16));
            end
            if (adr[15:8] >= TIMER_PAGE) begin
                adr[15] = 1'b0;
            end
            if (rand_bits(1) == 1) begin
                wdat = 8'(rand_bits(8));
                bus_write(adr, wdat);
                ram_model[adr[RAM_ADDR_W-1:0]] = wdat;
            end else begin
                read_expect("dat_o (ram)", adr, ram_model[adr[RAM_ADDR_W-1:0]]);
            end
        end
    endtask

    task automatic led_writes();
        read_expect("dat_o (leds)", LEDS_ADR, leds_model);
        for (int n = 0; n < N_LED_OPS; n++) begin
            leds_model = 8'(rand_bits(8));
            bus_write(LEDS_ADR, leds_model);
            check_value("leds_o", 32'(leds_model), 32'(ack_leds));
            read_expect("dat_o (leds)", LEDS_ADR, leds_model);
        end
    endtask

    task automatic prng_reads();
        for (int n = 0; n < N_PRNG_RD; n++) begin
            read_expect("dat_o (prng)", PRNG_ADR, prng_model);
            prng_model = galois_next(prng_model);
        end
    endtask

    task automatic prng_sequence();
        logic [DATA_W-1:0] seed;
        prng_reads();
        seed = 8'(rand_bits(8));
        bus_write(PRNG_ADR, seed);
        prng_model = (seed == 8'h00) ? PRNG_SEED : seed;
        prng_reads();
        // zero seed restarts from the reset value
        bus_write(PRNG_ADR, 8'h00);
        prng_model = PRNG_SEED;
        prng_reads();
    endtask

    task automatic timer_checks();
        int n;
        int period;
        read_expect("dat_o (tmr status)", tmr_adr(TMR_STATUS), 8'(tmr_pending));
        read_expect("dat_o (tmr ctrl)", tmr_adr(TMR_CTRL), 8'(tmr_en));
        tmr_reload = 16'(rand_bits(16));
        bus_write(tmr_adr(TMR_RELOAD_LO), tmr_reload[7:0]);
        bus_write(tmr_adr(TMR_RELOAD_HI), tmr_reload[15:8]);
        read_expect("dat_o (tmr reload lo)", tmr_adr(TMR_RELOAD_LO), tmr_reload[7:0]);
        read_expect("dat_o (tmr reload hi)", tmr_adr(TMR_RELOAD_HI), tmr_reload[15:8]);
        n = 2 + int'(rand_bits(8) % 39);
        tmr_reload = 16'(n);
        bus_write(tmr_adr(TMR_RELOAD_LO), tmr_reload[7:0]);
        bus_write(tmr_adr(TMR_RELOAD_HI), tmr_reload[15:8]);
        read_expect("dat_o (tmr reload lo)", tmr_adr(TMR_RELOAD_LO), tmr_reload[7:0]);
        // period counts from the enabling ack edge
        bus_write(tmr_adr(TMR_CTRL), CTRL_EN);
        tmr_en = 1'b1;
        irq_delay(MAX_RELOAD + 8, period);
        check_value("irq_o period", 32'(n + 1), 32'(period));
        tmr_pending = 1'b1;
        read_expect("dat_o (tmr status)", tmr_adr(TMR_STATUS), 8'(tmr_pending));
        read_expect("dat_o (tmr ctrl)", tmr_adr(TMR_CTRL), 8'(tmr_en));
        // clear and restart in one write, irq_o comes back one period later
        bus_write(tmr_adr(TMR_CTRL), CTRL_EN | CTRL_CLR);
        check_value("irq_o", 32'd0, 32'(irq_o));
        irq_delay(MAX_RELOAD + 8, period);
        check_value("irq_o period", 32'(n + 1), 32'(period));
        read_expect("dat_o (tmr status)", tmr_adr(TMR_STATUS), 8'(tmr_pending));
        bus_write(tmr_adr(TMR_CTRL), CTRL_CLR);
        tmr_en      = 1'b0;
        tmr_pending = 1'b0;
        check_value("irq_o", 32'd0, 32'(irq_o));
        read_expect("dat_o (tmr status)", tmr_adr(TMR_STATUS), 8'(tmr_pending));
        read_expect("dat_o (tmr ctrl)", tmr_adr(TMR_CTRL), 8'(tmr_en));
        // stopped timer stays quiet
        repeat (MAX_RELOAD + 4) @(negedge clk);
        check_value("irq_o", 32'd0, 32'(irq_o));
    endtask

    initial begin
        adr_i  = '0;
        dat_i  = '0;
        stb_i  = 1'b0;
        we_i   = 1'b0;
        lfsr_q = 16'd36;
        for (int i = 0; i < (1 << RAM_ADDR_W); i++) begin
            ram_model[i] = '0;
        end
        leds_model  = '0;
        prng_model  = PRNG_SEED;
        tmr_reload  = '0;
        tmr_en      = 1'b0;
        tmr_pending = 1'b0;
        @(posedge rst_n);
        check_value("ack_o", 32'd0, 32'(ack_o));
        check_value("irq_o", 32'd0, 32'(irq_o));
        check_value("leds_o", 32'd0, 32'(leds_o));
        ram_traffic();
        led_writes();
        prng_sequence();
        timer_checks();
        $display("TB PASSED");
        $finish;
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

// File: all.f
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/bus_arbiter.sv
hdl/bram_wb8.sv
hdl/leds_wb8.sv
hdl/prng_wb8.sv
hdl/timer_wb8.sv
hdl/soc_top.sv
tests/tb_clkgen.sv
tests/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run may stop with a nonzero status, the log search decides
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
